// File: core_consts.svh
// Core-wide constants: data width, register file size, instruction layout
// and the no-op instruction word

`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Data path and PC width
`define CORE_XLEN     32

// Register file
`define CORE_NR_REGS  8
`define CORE_REG_AW   3

// Instruction fields, opcode on top and immediate in the low half
`define CORE_OPC_LSB  28
`define CORE_RD_LSB   25
`define CORE_RS1_LSB  22
`define CORE_RS2_LSB  19
`define CORE_IMM_W    16

// ADDI r0, r0, 0
`define CORE_NOP      32'h0000_0000

`endif

// File: core_pkg.sv
// Opcode and ALU enums, structs passed between the pipeline stages

`include "core_consts.svh"

package core_pkg;

    // Unlisted codes behave as no-ops
    typedef enum logic [3:0] {
        OPC_ADDI = 4'h0,
        OPC_ADD  = 4'h1,
        OPC_SUB  = 4'h2,
        OPC_AND  = 4'h3,
        OPC_OR   = 4'h4,
        OPC_XOR  = 4'h5,
        OPC_SLL  = 4'h6,
        OPC_SRL  = 4'h7,
        OPC_LUI  = 4'h8,
        OPC_BEQ  = 4'h9,
        OPC_BNE  = 4'ha,
        OPC_JAL  = 4'hb
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        logic [`CORE_XLEN-1:0] instr;
    } fetch_entry_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0]   pc;
        alu_op_e                 alu_op;
        logic [`CORE_REG_AW-1:0] rd;
        logic [`CORE_REG_AW-1:0] rs1;
        logic [`CORE_REG_AW-1:0] rs2;
        logic [`CORE_XLEN-1:0]   imm;
        logic                    use_imm;
        logic                    is_branch;
        logic                    branch_ne;
        logic                    is_jump;
        logic                    rd_we;
    } decoded_instr_t;

    // Decoded instruction with its source values after forwarding
    typedef struct packed {
        decoded_instr_t        instr;
        logic [`CORE_XLEN-1:0] op_a;
        logic [`CORE_XLEN-1:0] op_b;
    } ex_entry_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0]   pc;
        logic [`CORE_REG_AW-1:0] rd;
        logic [`CORE_XLEN-1:0]   wdata;
        logic                    we;
    } commit_t;

    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] target;
    } redirect_t;

endpackage

// File: fetch_stage.sv
// Fetch stage: PC register, instruction port requests, wrong-path response
// dropping and the fetch entry register

`timescale 1ns/1ps

`include "core_consts.svh"

module fetch_stage (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    fetch_enable_i,
    input  logic [`CORE_XLEN-1:0]   boot_addr_i,
    input  core_pkg::redirect_t     redirect_i,
    // Instruction port
    output logic                    imem_req_o,
    output logic [`CORE_XLEN-1:0]   imem_addr_o,
    input  logic                    imem_valid_i,
    input  logic [`CORE_XLEN-1:0]   imem_rdata_i,
    // Toward issue
    output core_pkg::fetch_entry_t  fetch_entry_o,
    output logic                    fetch_valid_o
);

    logic [`CORE_XLEN-1:0] pc_q;
    logic [`CORE_XLEN-1:0] addr_q;
    logic [`CORE_XLEN-1:0] fetch_pc;
    logic                  boot_q;
    logic                  busy_q;
    logic                  drop_q;
    logic                  accept;
    logic                  valid_q;
    core_pkg::fetch_entry_t entry_q;

    // Boot address is used until the first fetch or redirect
    assign fetch_pc = boot_q ? boot_addr_i : pc_q;

    // An open request stays up, a new one waits out the redirect cycle
    assign imem_req_o  = busy_q | (fetch_enable_i & ~redirect_i.valid);
    assign imem_addr_o = busy_q ? addr_q : fetch_pc;

    // Response of a request made before a redirect is thrown away
    assign accept = imem_valid_i & ~drop_q & ~redirect_i.valid;

    // --------------------
    // Control state
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q    <= '0;
            boot_q  <= 1'b1;
            busy_q  <= 1'b0;
            drop_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            busy_q  <= imem_req_o & ~imem_valid_i;
            drop_q  <= (drop_q | redirect_i.valid) & imem_req_o & ~imem_valid_i;
            valid_q <= accept;
            if (redirect_i.valid) begin
                pc_q   <= redirect_i.target;
                boot_q <= 1'b0;
            end else if (accept) begin
                pc_q   <= imem_addr_o + `CORE_XLEN'd4;
                boot_q <= 1'b0;
            end
        end
    end

    // Request address held while the memory is busy
    always_ff @(posedge clk_i) begin
        addr_q <= imem_addr_o;
        if (accept) begin
            entry_q.pc    <= imem_addr_o;
            entry_q.instr <= imem_rdata_i;
        end
    end

    assign fetch_entry_o = entry_q;
    assign fetch_valid_o = valid_q;

endmodule

// File: decode_stage.sv
// Instruction decoder: opcode to ALU operation, control flags and immediate

`timescale 1ns/1ps

`include "core_consts.svh"

module decode_stage (
    input  core_pkg::fetch_entry_t   fetch_entry_i,
    output core_pkg::decoded_instr_t decoded_o
);

    localparam int unsigned OPC_W = $bits(core_pkg::opcode_e);

    core_pkg::opcode_e      opcode;
    logic [`CORE_IMM_W-1:0] imm16;

    assign opcode = core_pkg::opcode_e'(fetch_entry_i.instr[`CORE_OPC_LSB +: OPC_W]);
    assign imm16  = fetch_entry_i.instr[`CORE_IMM_W-1:0];

    always_comb begin
        decoded_o        = '0;
        decoded_o.pc     = fetch_entry_i.pc;
        decoded_o.rd     = fetch_entry_i.instr[`CORE_RD_LSB +: `CORE_REG_AW];
        decoded_o.rs1    = fetch_entry_i.instr[`CORE_RS1_LSB +: `CORE_REG_AW];
        decoded_o.rs2    = fetch_entry_i.instr[`CORE_RS2_LSB +: `CORE_REG_AW];
        decoded_o.imm    = {{(`CORE_XLEN-`CORE_IMM_W){imm16[`CORE_IMM_W-1]}}, imm16};
        decoded_o.alu_op = core_pkg::ALU_ADD;

        case (opcode)
            core_pkg::OPC_ADDI: begin
                decoded_o.use_imm = 1'b1;
                decoded_o.rd_we   = 1'b1;
            end
            core_pkg::OPC_ADD: decoded_o.rd_we = 1'b1;
            core_pkg::OPC_SUB: begin
                decoded_o.alu_op = core_pkg::ALU_SUB;
                decoded_o.rd_we  = 1'b1;
            end
            core_pkg::OPC_AND: begin
                decoded_o.alu_op = core_pkg::ALU_AND;
                decoded_o.rd_we  = 1'b1;
            end
            core_pkg::OPC_OR: begin
                decoded_o.alu_op = core_pkg::ALU_OR;
                decoded_o.rd_we  = 1'b1;
            end
            core_pkg::OPC_XOR: begin
                decoded_o.alu_op = core_pkg::ALU_XOR;
                decoded_o.rd_we  = 1'b1;
            end
            core_pkg::OPC_SLL: begin
                decoded_o.alu_op = core_pkg::ALU_SLL;
                decoded_o.rd_we  = 1'b1;
            end
            core_pkg::OPC_SRL: begin
                decoded_o.alu_op = core_pkg::ALU_SRL;
                decoded_o.rd_we  = 1'b1;
            end
            // Upper immediate added to r0
            core_pkg::OPC_LUI: begin
                decoded_o.rs1     = '0;
                decoded_o.imm     = {imm16, {(`CORE_XLEN-`CORE_IMM_W){1'b0}}};
                decoded_o.use_imm = 1'b1;
                decoded_o.rd_we   = 1'b1;
            end
            core_pkg::OPC_BEQ: decoded_o.is_branch = 1'b1;
            core_pkg::OPC_BNE: begin
                decoded_o.is_branch = 1'b1;
                decoded_o.branch_ne = 1'b1;
            end
            core_pkg::OPC_JAL: begin
                decoded_o.is_jump = 1'b1;
                decoded_o.rd_we   = 1'b1;
            end
            default: ;
        endcase

        // r0 is never written
        if (decoded_o.rd == '0) begin
            decoded_o.rd_we = 1'b0;
        end
    end

endmodule

// File: issue_stage.sv
// Issue stage with decode, register file, operand forwarding and the
// execute register

`timescale 1ns/1ps

`include "core_consts.svh"

module issue_stage (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  core_pkg::fetch_entry_t fetch_entry_i,
    input  logic                   fetch_valid_i,
    input  logic                   flush_i,
    // Unregistered forwarding from execute
    input  core_pkg::commit_t      ex_fwd_i,
    input  logic                   ex_fwd_valid_i,
    // Register write from commit
    input  core_pkg::commit_t      wb_i,
    input  logic                   wb_valid_i,
    output core_pkg::ex_entry_t    ex_entry_o,
    output logic                   ex_valid_o
);

    core_pkg::decoded_instr_t decoded;
    core_pkg::ex_entry_t      entry_q;
    logic                     valid_q;
    logic [`CORE_XLEN-1:0]    regs_q [`CORE_NR_REGS];
    logic [`CORE_XLEN-1:0]    op_a;
    logic [`CORE_XLEN-1:0]    op_b;

    decode_stage decode_stage_i (
        .fetch_entry_i ( fetch_entry_i ),
        .decoded_o     ( decoded       )
    );

    // Youngest producer wins, then the retiring one, then the register file
    function automatic logic [`CORE_XLEN-1:0] read_operand(
        input logic [`CORE_REG_AW-1:0] rs
    );
        logic [`CORE_XLEN-1:0] value;
        if (rs == '0) begin
            value = '0;
        end else if (ex_fwd_valid_i && ex_fwd_i.we && ex_fwd_i.rd == rs) begin
            value = ex_fwd_i.wdata;
        end else if (wb_valid_i && wb_i.we && wb_i.rd == rs) begin
            value = wb_i.wdata;
        end else begin
            value = regs_q[rs];
        end
        return value;
    endfunction

    always_comb begin
        op_a = read_operand(decoded.rs1);
        op_b = read_operand(decoded.rs2);
    end

    // --------------------
    // Register file
    // --------------------
    always_ff @(posedge clk_i) begin
        if (wb_valid_i && wb_i.we) begin
            regs_q[wb_i.rd] <= wb_i.wdata;
        end
    end

    // --------------------
    // Execute register
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fetch_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        entry_q.instr <= decoded;
        entry_q.op_a  <= op_a;
        entry_q.op_b  <= op_b;
    end

    assign ex_entry_o = entry_q;
    assign ex_valid_o = valid_q;

endmodule

// File: ex_stage.sv
// Execute stage: ALU, branch resolution and the registered redirect

`timescale 1ns/1ps

`include "core_consts.svh"

module ex_stage (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  core_pkg::ex_entry_t  ex_entry_i,
    input  logic                 ex_valid_i,
    input  logic                 flush_i,
    output core_pkg::commit_t    result_o,
    output logic                 result_valid_o,
    output core_pkg::redirect_t  redirect_o
);

    localparam int unsigned SHAMT_W = $clog2(`CORE_XLEN);

    logic [`CORE_XLEN-1:0] op_b;
    logic [`CORE_XLEN-1:0] alu_res;
    logic [`CORE_XLEN-1:0] target;
    logic                  taken;
    logic                  redirect_valid_q;
    logic [`CORE_XLEN-1:0] redirect_target_q;

    assign op_b = ex_entry_i.instr.use_imm ? ex_entry_i.instr.imm : ex_entry_i.op_b;

    always_comb begin
        case (ex_entry_i.instr.alu_op)
            core_pkg::ALU_SUB: alu_res = ex_entry_i.op_a - op_b;
            core_pkg::ALU_AND: alu_res = ex_entry_i.op_a & op_b;
            core_pkg::ALU_OR:  alu_res = ex_entry_i.op_a | op_b;
            core_pkg::ALU_XOR: alu_res = ex_entry_i.op_a ^ op_b;
            core_pkg::ALU_SLL: alu_res = ex_entry_i.op_a << op_b[SHAMT_W-1:0];
            core_pkg::ALU_SRL: alu_res = ex_entry_i.op_a >> op_b[SHAMT_W-1:0];
            default:           alu_res = ex_entry_i.op_a + op_b;
        endcase
    end

    // Branch compares the two register values, offset counts words
    assign taken = ex_entry_i.instr.is_jump
                 | (ex_entry_i.instr.is_branch
                    & ((ex_entry_i.op_a == ex_entry_i.op_b) ^ ex_entry_i.instr.branch_ne));
    assign target = ex_entry_i.instr.pc + {ex_entry_i.instr.imm[`CORE_XLEN-3:0], 2'b00};

    // Unregistered result also serves as the forwarding source
    assign result_o.pc    = ex_entry_i.instr.pc;
    assign result_o.rd    = ex_entry_i.instr.rd;
    assign result_o.we    = ex_entry_i.instr.rd_we;
    assign result_o.wdata = ex_entry_i.instr.is_jump ?
                            ex_entry_i.instr.pc + `CORE_XLEN'd4 : alu_res;
    assign result_valid_o = ex_valid_i & ~flush_i;

    // --------------------
    // Redirect register
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            redirect_valid_q <= 1'b0;
        end else begin
            redirect_valid_q <= result_valid_o & taken;
        end
    end

    always_ff @(posedge clk_i) begin
        redirect_target_q <= target;
    end

    assign redirect_o.valid  = redirect_valid_q;
    assign redirect_o.target = redirect_target_q;

endmodule

// File: commit_stage.sv
// Commit stage: retire register feeding the commit port and the register
// file write

`timescale 1ns/1ps

module commit_stage (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  core_pkg::commit_t result_i,
    input  logic              result_valid_i,
    output core_pkg::commit_t commit_o,
    output logic              commit_valid_o
);

    core_pkg::commit_t commit_q;
    logic              commit_valid_q;

    // Nothing past this point can be squashed
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            commit_valid_q <= 1'b0;
        end else begin
            commit_valid_q <= result_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (result_valid_i) begin
            commit_q <= result_i;
        end
    end

    assign commit_o       = commit_q;
    assign commit_valid_o = commit_valid_q;

endmodule

// File: core_top.sv
// Core top level: fetch enable register and the stage chain from fetch to
// commit

`timescale 1ns/1ps

`include "core_consts.svh"

module core_top (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  fetch_enable_i,
    input  logic [`CORE_XLEN-1:0] boot_addr_i,
    // Instruction port
    output logic                  imem_req_o,
    output logic [`CORE_XLEN-1:0] imem_addr_o,
    input  logic                  imem_valid_i,
    input  logic [`CORE_XLEN-1:0] imem_rdata_i,
    // Retired instructions
    output logic                  commit_valid_o,
    output core_pkg::commit_t     commit_o
);

    logic                   fetch_enable;
    core_pkg::fetch_entry_t fetch_entry;
    logic                   fetch_valid;
    core_pkg::ex_entry_t    ex_entry;
    logic                   ex_valid;
    core_pkg::commit_t      ex_result;
    logic                   ex_result_valid;
    core_pkg::redirect_t    redirect;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fetch_enable <= 1'b0;
        end else begin
            fetch_enable <= fetch_enable_i;
        end
    end

    // --------------------
    // Fetch
    // --------------------
    fetch_stage fetch_stage_i (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .fetch_enable_i ( fetch_enable   ),
        .boot_addr_i    ( boot_addr_i    ),
        .redirect_i     ( redirect       ),
        .imem_req_o     ( imem_req_o     ),
        .imem_addr_o    ( imem_addr_o    ),
        .imem_valid_i   ( imem_valid_i   ),
        .imem_rdata_i   ( imem_rdata_i   ),
        .fetch_entry_o  ( fetch_entry    ),
        .fetch_valid_o  ( fetch_valid    )
    );

    // --------------------
    // Issue
    // --------------------
    issue_stage issue_stage_i (
        .clk_i          ( clk_i           ),
        .rst_ni         ( rst_ni          ),
        .fetch_entry_i  ( fetch_entry     ),
        .fetch_valid_i  ( fetch_valid     ),
        .flush_i        ( redirect.valid  ),
        .ex_fwd_i       ( ex_result       ),
        .ex_fwd_valid_i ( ex_result_valid ),
        .wb_i           ( commit_o        ),
        .wb_valid_i     ( commit_valid_o  ),
        .ex_entry_o     ( ex_entry        ),
        .ex_valid_o     ( ex_valid        )
    );

    // --------------------
    // Execute
    // --------------------
    ex_stage ex_stage_i (
        .clk_i          ( clk_i           ),
        .rst_ni         ( rst_ni          ),
        .ex_entry_i     ( ex_entry        ),
        .ex_valid_i     ( ex_valid        ),
        .flush_i        ( redirect.valid  ),
        .result_o       ( ex_result       ),
        .result_valid_o ( ex_result_valid ),
        .redirect_o     ( redirect        )
    );

    // --------------------
    // Commit
    // --------------------
    commit_stage commit_stage_i (
        .clk_i          ( clk_i           ),
        .rst_ni         ( rst_ni          ),
        .result_i       ( ex_result       ),
        .result_valid_i ( ex_result_valid ),
        .commit_o       ( commit_o        ),
        .commit_valid_o ( commit_valid_o  )
    );

endmodule

// File: tb_clock.sv
// Testbench clock and reset generator, reset repeated on request

`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    input  logic reset_req_i,
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset spans RESET_CYCLES rising edges and is released on a falling edge
    initial begin
        rst_no = 1'b0;
        forever begin
            repeat (RESET_CYCLES) @(posedge clk_o);
            @(negedge clk_o);
            rst_no = 1'b1;
            @(posedge reset_req_i);
            rst_no = 1'b0;
        end
    end

endmodule

// File: tb_core.sv
// Core testbench with random programs, instruction memory with random delays,
// ISA reference model and in-order commit checks

`timescale 1ns/1ps

`include "core_consts.svh"

module tb_core;

    localparam int PERIOD_NS   = 40;
    localparam int PROG_WORDS  = 64;
    localparam int MODE_ALU    = 0;
    localparam int MODE_CHAIN  = 1;
    localparam int MODE_BRANCH = 2;

    // Commits per test
    localparam int N_BOOT   = 20;
    localparam int N_ALU    = 200;
    localparam int N_CHAIN  = 150;
    localparam int N_BRANCH = 200;
    localparam int N_ENABLE = 120;
    localparam int N_TOTAL  = N_BOOT + N_ALU + N_CHAIN + N_BRANCH + N_ENABLE;
    localparam int WATCHDOG_CYCLES = N_TOTAL * 40 + 200;
    localparam int WATCHDOG_NS     = WATCHDOG_CYCLES * PERIOD_NS;

    logic                  clk;
    logic                  rst_n;
    logic                  reset_req;
    logic                  fetch_enable;
    logic [`CORE_XLEN-1:0] boot_addr;
    logic                  imem_req;
    logic [`CORE_XLEN-1:0] imem_addr;
    logic                  imem_valid;
    logic [`CORE_XLEN-1:0] imem_rdata;
    logic                  commit_valid;
    core_pkg::commit_t     commit;

    // Testbench state
    logic [31:0]           lfsr_q;
    logic [`CORE_XLEN-1:0] prog [PROG_WORDS];
    logic [`CORE_XLEN-1:0] model_regs [`CORE_NR_REGS];
    logic [`CORE_XLEN-1:0] model_pc;
    logic [`CORE_XLEN-1:0] first_pc;
    logic [`CORE_XLEN-1:0] req_addr;
    logic                  enable_next;
    logic                  random_delay;
    logic                  pending;
    int                    wait_cnt;
    int                    commits;
    int                    errors;
    int                    errors_at_start;
    int                    tests_run;
    int                    tests_passed;
    int                    base;

    tb_clock #(
        .PERIOD_NS    ( PERIOD_NS ),
        .RESET_CYCLES ( 2         )
    ) clock_i (
        .reset_req_i ( reset_req ),
        .clk_o       ( clk       ),
        .rst_no      ( rst_n     )
    );

    core_top dut_i (
        .clk_i          ( clk          ),
        .rst_ni         ( rst_n        ),
        .fetch_enable_i ( fetch_enable ),
        .boot_addr_i    ( boot_addr    ),
        .imem_req_o     ( imem_req     ),
        .imem_addr_o    ( imem_addr    ),
        .imem_valid_i   ( imem_valid   ),
        .imem_rdata_i   ( imem_rdata   ),
        .commit_valid_o ( commit_valid ),
        .commit_o       ( commit       )
    );

    // --------------------
    // Random numbers
    // --------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value  = {value[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return value;
    endfunction

    // --------------------
    // Programs and memory
    // --------------------
    function automatic logic [31:0] encode_instr(
        input logic [3:0]              opc,
        input logic [`CORE_REG_AW-1:0] rd,
        input logic [`CORE_REG_AW-1:0] rs1,
        input logic [`CORE_REG_AW-1:0] rs2,
        input logic [`CORE_IMM_W-1:0]  imm
    );
        logic [31:0] word;
        word = '0;
        word[`CORE_OPC_LSB +: 4]           = opc;
        word[`CORE_RD_LSB +: `CORE_REG_AW]  = rd;
        word[`CORE_RS1_LSB +: `CORE_REG_AW] = rs1;
        word[`CORE_RS2_LSB +: `CORE_REG_AW] = rs2;
        word[`CORE_IMM_W-1:0]              = imm;
        return word;
    endfunction

    // NOP outside the program
    function automatic logic [31:0] program_word(input logic [31:0] addr);
        logic [31:0] index;
        logic [31:0] word;
        index = (addr - boot_addr) >> 2;
        word  = `CORE_NOP;
        if (index < PROG_WORDS) begin
            word = prog[index[5:0]];
        end
        return word;
    endfunction

    task automatic make_program(input int mode);
        logic [3:0]              opc;
        logic [`CORE_REG_AW-1:0] rd;
        logic [`CORE_REG_AW-1:0] rs1;
        logic [`CORE_REG_AW-1:0] rs2;
        logic [`CORE_REG_AW-1:0] last_rd;
        logic [`CORE_REG_AW-1:0] older_rd;
        logic [`CORE_IMM_W-1:0]  imm;
        last_rd  = 3'd7;
        older_rd = 3'd6;
        // Prologue gives every register a known value
        for (int i = 0; i < `CORE_NR_REGS - 1; i++) begin
            prog[i] = encode_instr(core_pkg::OPC_ADDI, 3'(i + 1), 3'd0, 3'd0,
                                   16'(random_bits(16)));
        end
        for (int i = `CORE_NR_REGS - 1; i < PROG_WORDS; i++) begin
            opc = 4'(random_bits(4) % 32'd9);
            rd  = 3'(random_bits(3));
            rs1 = 3'(random_bits(3));
            rs2 = 3'(random_bits(3));
            imm = 16'(random_bits(16));
            if (mode == MODE_CHAIN) begin
                rd = 3'(32'd1 + random_bits(3) % 32'd7);
                if (random_bits(1) == 32'd1) begin
                    rs1 = last_rd;
                    rs2 = older_rd;
                end else begin
                    rs1 = older_rd;
                    rs2 = last_rd;
                end
                older_rd = last_rd;
                last_rd  = rd;
            end else if (mode == MODE_BRANCH && random_bits(2) == 32'd0) begin
                // Word offset to a target inside the program
                opc = 4'(32'd9 + random_bits(2) % 32'd3);
                imm = 16'(int'(random_bits(6)) - i);
            end
            prog[i] = encode_instr(opc, rd, rs1, rs2, imm);
        end
    endtask

    // Answers the open request after 0 to 3 cycles
    // A delay of zero answers in the same cycle as the request
    task automatic drive_memory();
        if (imem_valid) begin
            imem_valid = 1'b0;
            pending    = 1'b0;
        end
        // An open request holds its strobe and address until answered
        if (pending) begin
            if (imem_req !== 1'b1) begin
                $display("FAILED imem_req_o: got %h, expected 1", imem_req);
                errors++;
            end
            if (imem_addr !== req_addr) begin
                $display("FAILED imem_addr_o: got %h, expected %h", imem_addr, req_addr);
                errors++;
            end
        end
        if (imem_req) begin
            if (!pending) begin
                pending  = 1'b1;
                req_addr = imem_addr;
                wait_cnt = random_delay ? int'(random_bits(2)) : 0;
            end else if (wait_cnt > 0) begin
                wait_cnt--;
            end
            if (wait_cnt == 0) begin
                imem_valid = 1'b1;
                imem_rdata = program_word(imem_addr);
            end
        end
    endtask

    // --------------------
    // ISA model
    // --------------------
    task automatic model_step(
        output logic [`CORE_XLEN-1:0]   pc,
        output logic [`CORE_REG_AW-1:0] rd,
        output logic                    we,
        output logic [`CORE_XLEN-1:0]   wdata
    );
        logic [31:0]           instr;
        logic [3:0]            opc;
        logic [`CORE_XLEN-1:0] a;
        logic [`CORE_XLEN-1:0] b;
        logic [`CORE_XLEN-1:0] simm;
        logic [`CORE_XLEN-1:0] next_pc;
        instr   = program_word(model_pc);
        opc     = instr[`CORE_OPC_LSB +: 4];
        rd      = instr[`CORE_RD_LSB +: `CORE_REG_AW];
        a       = model_regs[instr[`CORE_RS1_LSB +: `CORE_REG_AW]];
        b       = model_regs[instr[`CORE_RS2_LSB +: `CORE_REG_AW]];
        simm    = {{16{instr[15]}}, instr[15:0]};
        pc      = model_pc;
        next_pc = model_pc + 32'd4;
        we      = 1'b1;
        wdata   = '0;
        case (opc)
            core_pkg::OPC_ADDI: wdata = a + simm;
            core_pkg::OPC_ADD:  wdata = a + b;
            core_pkg::OPC_SUB:  wdata = a - b;
            core_pkg::OPC_AND:  wdata = a & b;
            core_pkg::OPC_OR:   wdata = a | b;
            core_pkg::OPC_XOR:  wdata = a ^ b;
            core_pkg::OPC_SLL:  wdata = a << b[4:0];
            core_pkg::OPC_SRL:  wdata = a >> b[4:0];
            core_pkg::OPC_LUI:  wdata = {instr[15:0], 16'h0000};
            core_pkg::OPC_BEQ: begin
                we = 1'b0;
                if (a == b) begin
                    next_pc = model_pc + (simm << 2);
                end
            end
            core_pkg::OPC_BNE: begin
                we = 1'b0;
                if (a != b) begin
                    next_pc = model_pc + (simm << 2);
                end
            end
            core_pkg::OPC_JAL: begin
                wdata   = model_pc + 32'd4;
                next_pc = model_pc + (simm << 2);
            end
            default: we = 1'b0;
        endcase
        if (rd == 3'd0) begin
            we = 1'b0;
        end
        if (we) begin
            model_regs[rd] = wdata;
        end
        model_pc = next_pc;
    endtask

    // --------------------
    // Cycle and test control
    // --------------------
    task automatic check_commit();
        logic [`CORE_XLEN-1:0]   exp_pc;
        logic [`CORE_XLEN-1:0]   exp_wdata;
        logic [`CORE_REG_AW-1:0] exp_rd;
        logic                    exp_we;
        if (commit_valid) begin
            model_step(exp_pc, exp_rd, exp_we, exp_wdata);
            if (commits == 0) begin
                first_pc = commit.pc;
            end
            if (commit.pc !== exp_pc) begin
                $display("FAILED commit_o.pc: got %h, expected %h", commit.pc, exp_pc);
                errors++;
            end
            if (commit.rd !== exp_rd) begin
                $display("FAILED commit_o.rd: got %h, expected %h", commit.rd, exp_rd);
                errors++;
            end
            if (commit.we !== exp_we) begin
                $display("FAILED commit_o.we: got %h, expected %h", commit.we, exp_we);
                errors++;
            end
            if (exp_we && commit.wdata !== exp_wdata) begin
                $display("FAILED commit_o.wdata: got %h, expected %h",
                         commit.wdata, exp_wdata);
                errors++;
            end
            commits++;
        end
    endtask

    // Drive after the rising edge, sample on the falling edge
    task automatic step_cycle();
        @(posedge clk);
        #2;
        fetch_enable = enable_next;
        drive_memory();
        @(negedge clk);
        check_commit();
    endtask

    task automatic apply_reset(input logic [31:0] boot);
        @(posedge clk);
        #2;
        fetch_enable = 1'b0;
        boot_addr    = boot;
        imem_valid   = 1'b0;
        pending      = 1'b0;
        reset_req    = 1'b1;
        @(posedge rst_n);
        reset_req = 1'b0;
    endtask

    task automatic start_test(input int mode, input logic [31:0] boot, input logic delays);
        make_program(mode);
        enable_next     = 1'b0;
        random_delay    = delays;
        apply_reset(boot);
        model_pc        = boot;
        for (int i = 0; i < `CORE_NR_REGS; i++) begin
            model_regs[i] = '0;
        end
        commits         = 0;
        errors_at_start = errors;
    endtask

    task automatic run_commits(input int n);
        while (commits < n) begin
            step_cycle();
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("%-14s %0d commits, pass", name, commits);
        end else begin
            $display("%-14s %0d commits, %0d errors, fail", name, commits,
                     errors - errors_at_start);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog: run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        lfsr_q       = 32'h9153;
        reset_req    = 1'b0;
        fetch_enable = 1'b0;
        enable_next  = 1'b0;
        boot_addr    = 32'h0000_1000;
        imem_valid   = 1'b0;
        imem_rdata   = '0;
        random_delay = 1'b0;
        pending      = 1'b0;
        req_addr     = '0;
        wait_cnt     = 0;
        errors       = 0;
        tests_run    = 0;
        tests_passed = 0;
        wait (rst_n === 1'b1);

        // Quiet outputs after reset and the first commit at the boot address
        start_test(MODE_ALU, 32'h0000_1000, 1'b0);
        repeat (2) step_cycle();
        if (imem_req !== 1'b0) begin
            $display("FAILED imem_req_o: got %h, expected 0", imem_req);
            errors++;
        end
        if (commit_valid !== 1'b0) begin
            $display("FAILED commit_valid_o: got %h, expected 0", commit_valid);
            errors++;
        end
        enable_next = 1'b1;
        run_commits(N_BOOT);
        if (first_pc !== 32'h0000_1000) begin
            $display("FAILED first commit_o.pc: got %h, expected %h", first_pc, 32'h1000);
            errors++;
        end
        finish_test("reset_boot");

        start_test(MODE_ALU, 32'h0000_2000, 1'b0);
        enable_next = 1'b1;
        run_commits(N_ALU);
        finish_test("alu_random");

        // Back-to-back responses exercise both forwarding paths
        start_test(MODE_CHAIN, 32'h0000_3000, 1'b0);
        enable_next = 1'b1;
        run_commits(N_CHAIN);
        finish_test("dep_chain");

        start_test(MODE_BRANCH, 32'h0000_4000, 1'b1);
        enable_next = 1'b1;
        run_commits(N_BRANCH);
        finish_test("branch_jump");

        // Fetch paused mid-run and then resumed
        start_test(MODE_BRANCH, 32'h0000_5000, 1'b1);
        enable_next = 1'b1;
        run_commits(40);
        enable_next = 1'b0;
        base = commits;
        repeat (20) step_cycle();
        if (commits - base > 4) begin
            $display("Fetch disable: %0d commits after the drop, at most 4 allowed",
                     commits - base);
            errors++;
        end
        base = commits;
        repeat (50) step_cycle();
        if (commits != base) begin
            $display("Fetch disable: %0d commits while fetch was disabled", commits - base);
            errors++;
        end
        enable_next = 1'b1;
        run_commits(N_ENABLE);
        finish_test("fetch_enable");

        $display("%0d tests run, %0d passed, %0d errors", tests_run, tests_passed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+.
core_pkg.sv
fetch_stage.sv
decode_stage.sv
issue_stage.sv
ex_stage.sv
commit_stage.sv
core_top.sv
tb_clock.sv
tb_core.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and pass only when the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_core -f filelist.f -o tb_core_sim || exit 1
out="$(./obj_dir/tb_core_sim)"
echo "$out"
echo "$out" | grep -q "TEST OK" && exit 0 || exit 1
